// File: build.f
cache_pkg.sv
sram_2k8.sv
tag_store.sv
data_store.sv
clear_counter.sv
cache_ctrl.sv
cache_top.sv
cache_tb.sv

// File: Bender.yml
package:
  name: wb_cache

sources:
  - cache_pkg.sv
  - sram_2k8.sv
  - tag_store.sv
  - data_store.sv
  - clear_counter.sv
  - cache_ctrl.sv
  - cache_top.sv
  - target: simulation
    files:
      - cache_tb.sv

// File: cache_tb.sv
`timescale 1ns/1ps

module cache_tb;

  import cache_pkg::*;

  localparam int CLK_PERIOD     = 4;
  localparam int SWEEP_CYCLES   = NUM_LINES;         // One index per cycle
  localparam int HIT_LAT        = 2;                 // LOOKUP cycle, then ack in DONE
  localparam int MAX_OP_CYCLES  = 8;                 // Miss with 3 wait states plus handshake
  localparam int NUM_RANDOM     = 200;
  localparam int NUM_OPS        = 9 + NUM_RANDOM;    // Directed plus random accesses
  localparam int TIMEOUT_CYCLES = NUM_OPS * MAX_OP_CYCLES + SWEEP_CYCLES + 64;
  localparam int MEM_WORDS      = 1 << (TAG_BITS + INDEX_BITS);
  localparam int SEED           = 32'h1edaf19b;

  logic  clk = 1'b0;
  logic  reset_n;
  logic  cpu_cyc;
  logic  cpu_stb;
  logic  cpu_we;
  addr_t cpu_adr;
  word_t cpu_dat_w;
  word_t cpu_dat_r;
  logic  cpu_ack;
  logic  mem_cyc;
  logic  mem_stb;
  logic  mem_we;
  addr_t mem_adr;
  word_t mem_dat_w;
  word_t mem_dat_r;
  logic  mem_ack;

  word_t  shadow [MEM_WORDS];  // Backing memory contents
  integer stim_seed;
  integer mem_seed;
  int     errors      = 0;
  int     checks      = 0;
  int     ack_count   = 0;
  int     cycle_count = 0;
  int     txn_count   = 0;     // Completed memory transactions
  addr_t  last_adr;            // Last memory transaction
  logic   last_we;
  word_t  last_dat;
  logic   mem_busy = 1'b0;
  int     wait_left;

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  cache_top cache_top_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .cpu_cyc   (cpu_cyc),
    .cpu_stb   (cpu_stb),
    .cpu_we    (cpu_we),
    .cpu_adr   (cpu_adr),
    .cpu_dat_w (cpu_dat_w),
    .cpu_dat_r (cpu_dat_r),
    .cpu_ack   (cpu_ack),
    .mem_cyc   (mem_cyc),
    .mem_stb   (mem_stb),
    .mem_we    (mem_we),
    .mem_adr   (mem_adr),
    .mem_dat_w (mem_dat_w),
    .mem_dat_r (mem_dat_r),
    .mem_ack   (mem_ack)
  );

  // Power-up memory content, every address bit folded in
  function automatic word_t fill_word(input addr_t adr);
    return adr[15:0] ^ {adr[17:16], adr[17:16], 12'h5c3};
  endfunction

  // Expected CPU read data is whatever backing memory holds now
  function automatic word_t expected_word(input addr_t adr);
    return shadow[adr];
  endfunction

  // Small address set with index collisions
  function automatic addr_t pick_addr(input int k);
    case (k)
      0:       return {7'h01, 11'h010};
      1:       return {7'h22, 11'h010};  // Same index as 0
      2:       return {7'h00, 11'h7ff};
      3:       return {7'h7f, 11'h7ff};
      4:       return {7'h03, 11'h123};
      5:       return {7'h03, 11'h124};
      6:       return {7'h10, 11'h000};
      default: return {7'h55, 11'h000};
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED t=%0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic issue_request(input logic we, input addr_t adr, input word_t dat);
    @(negedge clk);
    cpu_cyc   = 1'b1;
    cpu_stb   = 1'b1;
    cpu_we    = we;
    cpu_adr   = adr;
    cpu_dat_w = dat;
  endtask

  // Waits for ack, lat counts cycles from the request
  task automatic complete_request(output word_t rdata, output int lat);
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (cpu_ack !== 1'b1);
    rdata = cpu_dat_r;
    @(negedge clk);  // Ack sampled on the edge in between
    check_value("cpu_ack", cpu_ack, 1'b0);  // Single-cycle ack
    cpu_cyc = 1'b0;
    cpu_stb = 1'b0;
    cpu_we  = 1'b0;
  endtask

  task automatic access(input logic we, input addr_t adr, input word_t dat,
                        output word_t rdata, output int lat, output int txns);
    int txn_start;
    txn_start = txn_count;
    issue_request(we, adr, dat);
    complete_request(rdata, lat);
    txns = txn_count - txn_start;
  endtask

  // Wishbone memory model, 0 to 3 wait states per transaction
  always @(negedge clk) begin
    if (mem_ack) begin
      mem_ack <= 1'b0;  // One ack per request
      mem_busy = 1'b0;
    end else if (mem_cyc && mem_stb) begin
      if (!mem_busy) begin
        mem_busy  = 1'b1;
        wait_left = $unsigned($random(mem_seed)) % 4;
      end
      if (wait_left == 0) begin
        mem_ack <= 1'b1;
        txn_count++;
        last_adr = mem_adr;
        last_we  = mem_we;
        last_dat = mem_dat_w;
        if (mem_we) begin
          shadow[mem_adr] = mem_dat_w;
        end else begin
          mem_dat_r <= shadow[mem_adr];
        end
      end else begin
        wait_left--;
      end
    end
  end

  // Every CPU ack checked against the reference
  always @(posedge clk) begin
    if (reset_n === 1'b1 && cpu_ack === 1'b1) begin
      ack_count++;
      checks++;
      assert (cpu_cyc && cpu_stb) else begin
        errors++;
        $display("cpu_ack raised at %0t with no request on the CPU bus", $time);
      end
      if (!cpu_we) begin
        check_value("cpu_dat_r", cpu_dat_r, expected_word(cpu_adr));
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  initial begin
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("Timeout, run still busy after %0d cycles", TIMEOUT_CYCLES);
    $display("Errors: %0d, checks: %0d, acks: %0d", errors, checks, ack_count);
    $display("Checks failed");
    $finish;
  end

  initial begin
    word_t rdata;
    int    lat;
    int    txns;
    int    k;
    addr_t adr;
    addr_t adr_b;
    word_t wdat;
    logic  we;

    reset_n   = 1'b0;
    cpu_cyc   = 1'b0;
    cpu_stb   = 1'b0;
    cpu_we    = 1'b0;
    cpu_adr   = '0;
    cpu_dat_w = '0;
    mem_dat_r = '0;
    mem_ack   = 1'b0;
    stim_seed = SEED;
    mem_seed  = SEED;
    for (k = 0; k < MEM_WORDS; k++) begin
      shadow[k] = fill_word(addr_t'(k));
    end

    repeat (2) begin  // Two reset cycles
      @(negedge clk);
      check_value("cpu_ack", cpu_ack, 1'b0);
      check_value("mem_cyc", mem_cyc, 1'b0);
      check_value("mem_stb", mem_stb, 1'b0);
      check_value("mem_we", mem_we, 1'b0);
    end
    reset_n = 1'b1;

    // Request held across the tag sweep
    adr  = 18'h00123;
    txns = txn_count;
    issue_request(1'b0, adr, '0);
    repeat (SWEEP_CYCLES) begin
      @(negedge clk);
      check_value("cpu_ack", cpu_ack, 1'b0);
      check_value("mem_cyc", mem_cyc, 1'b0);
      check_value("mem_stb", mem_stb, 1'b0);
    end
    complete_request(rdata, lat);
    check_value("cpu_dat_r", rdata, fill_word(adr));
    check_value("mem transactions", txn_count - txns, 1);
    check_value("mem_adr", last_adr, adr);

    // Read miss, then hit on the same address
    adr = {7'h40, 11'h456};
    access(1'b0, adr, '0, rdata, lat, txns);
    check_value("cpu_dat_r", rdata, fill_word(adr));
    check_value("mem transactions", txns, 1);
    check_value("mem_adr", last_adr, adr);
    check_value("mem_we", last_we, 1'b0);
    access(1'b0, adr, '0, rdata, lat, txns);
    check_value("cpu_dat_r", rdata, fill_word(adr));
    check_value("mem transactions", txns, 0);
    check_value("hit latency", lat, HIT_LAT);

    // Write-through, then read back as a hit
    adr  = {7'h11, 11'h789};
    wdat = 16'hbeef;
    access(1'b1, adr, wdat, rdata, lat, txns);
    check_value("mem transactions", txns, 1);
    check_value("mem_adr", last_adr, adr);
    check_value("mem_we", last_we, 1'b1);
    check_value("mem_dat_w", last_dat, wdat);
    access(1'b0, adr, '0, rdata, lat, txns);
    check_value("cpu_dat_r", rdata, wdat);
    check_value("mem transactions", txns, 0);
    check_value("hit latency", lat, HIT_LAT);

    // Same index, two tags, each evicts the other
    adr_b = {7'h4b, 11'h3a1};
    for (k = 0; k < 4; k++) begin
      adr = (k % 2 == 0) ? {7'h05, 11'h3a1} : adr_b;
      access(1'b0, adr, '0, rdata, lat, txns);
      check_value("cpu_dat_r", rdata, fill_word(adr));
      check_value("mem transactions", txns, 1);
      check_value("mem_adr", last_adr, adr);
    end

    // Random mix over the small address set
    for (k = 0; k < NUM_RANDOM; k++) begin
      adr  = pick_addr($unsigned($random(stim_seed)) % 8);
      we   = $random(stim_seed);
      wdat = $random(stim_seed);
      access(we, adr, wdat, rdata, lat, txns);
      if (we) begin
        check_value("mem transactions", txns, 1);
        check_value("mem_adr", last_adr, adr);
        check_value("mem_dat_w", last_dat, wdat);
      end else begin
        check_value("cpu_dat_r", rdata, expected_word(adr));
      end
    end

    repeat (2) @(negedge clk);
    check_value("ack count", ack_count, NUM_OPS);
    $display("Errors: %0d, checks: %0d, acks: %0d", errors, checks, ack_count);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: cache_top.sv
`timescale 1ns/1ps

// Direct-mapped write-through cache between two Wishbone classic ports
module cache_top (
  input  logic              clk,
  input  logic              reset_n,
  // CPU side, Wishbone slave
  input  logic              cpu_cyc,
  input  logic              cpu_stb,
  input  logic              cpu_we,
  input  cache_pkg::addr_t  cpu_adr,
  input  cache_pkg::word_t  cpu_dat_w,
  output cache_pkg::word_t  cpu_dat_r,
  output logic              cpu_ack,
  // Memory side, Wishbone master
  output logic              mem_cyc,
  output logic              mem_stb,
  output logic              mem_we,
  output cache_pkg::addr_t  mem_adr,
  output cache_pkg::word_t  mem_dat_w,
  input  cache_pkg::word_t  mem_dat_r,
  input  logic              mem_ack
);

  import cache_pkg::*;

  tag_t   cpu_tag;      // Upper address bits
  index_t cpu_index;    // Line select
  index_t clear_index;  // Sweep position
  index_t store_index;  // Address seen by both stores
  word_t  rd_word;      // Cached word

  logic hit;
  logic clear_start;
  logic clear_done;
  logic clearing;
  logic tag_we;
  logic data_we;
  logic fill_sel;

  assign {cpu_tag, cpu_index} = cpu_adr;

  // Sweep owns the store address until it ends
  assign store_index = clearing ? clear_index : cpu_index;

  // Write-through and fills use the CPU request as is
  assign mem_adr   = cpu_adr;
  assign mem_dat_w = cpu_dat_w;

  // Memory word passes straight through during the fill ack
  assign cpu_dat_r = fill_sel ? mem_dat_r : rd_word;

  cache_ctrl cache_ctrl_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .cpu_cyc     (cpu_cyc),
    .cpu_stb     (cpu_stb),
    .cpu_we      (cpu_we),
    .cpu_ack     (cpu_ack),
    .hit         (hit),
    .clear_done  (clear_done),
    .clear_start (clear_start),
    .clearing    (clearing),
    .mem_cyc     (mem_cyc),
    .mem_stb     (mem_stb),
    .mem_we      (mem_we),
    .mem_ack     (mem_ack),
    .tag_we      (tag_we),
    .data_we     (data_we),
    .fill_sel    (fill_sel)
  );

  clear_counter clear_counter_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .clear_start (clear_start),
    .clear_index (clear_index),
    .clear_done  (clear_done)
  );

  tag_store tag_store_i (
    .clk      (clk),
    .index    (store_index),
    .tag      (cpu_tag),
    .tag_we   (tag_we),
    .clearing (clearing),
    .hit      (hit)
  );

  data_store data_store_i (
    .clk      (clk),
    .index    (store_index),
    .data_we  (data_we),
    .fill_sel (fill_sel),
    .cpu_word (cpu_dat_w),
    .mem_word (mem_dat_r),
    .rd_word  (rd_word)
  );

endmodule

// File: cache_ctrl.sv
`timescale 1ns/1ps

// Cache sequencer: sweep, lookup, miss fill and write-through
module cache_ctrl (
  input  logic clk,
  input  logic reset_n,
  // CPU side handshake
  input  logic cpu_cyc,
  input  logic cpu_stb,
  input  logic cpu_we,
  output logic cpu_ack,
  // Store status
  input  logic hit,
  input  logic clear_done,
  output logic clear_start,
  output logic clearing,
  // Memory side handshake
  output logic mem_cyc,
  output logic mem_stb,
  output logic mem_we,
  input  logic mem_ack,
  // Store controls
  output logic tag_we,
  output logic data_we,
  output logic fill_sel
);

  import cache_pkg::*;

  ctrl_state_t state;
  ctrl_state_t next_state;

  logic start_q;    // Start pulse, armed by reset
  logic ack_q;      // Registered CPU ack
  logic mem_cyc_q;  // Memory cycle active
  logic mem_stb_q;  // Memory strobe
  logic mem_we_q;   // Memory write
  logic cpu_req;    // Valid request on the CPU port
  logic mem_bus;    // Next state owns the memory bus

  assign cpu_req = cpu_cyc && cpu_stb;

  // Next state
  always_comb begin
    next_state = state;
    unique case (state)
      CLEAR: begin
        if (clear_done) next_state = IDLE;  // Requests wait here unacked
      end
      IDLE: begin
        if (cpu_req) next_state = LOOKUP;
      end
      LOOKUP: begin
        if (cpu_we) begin
          next_state = WRITE;  // Every write goes to memory
        end else if (hit) begin
          next_state = DONE;
        end else begin
          next_state = FILL;
        end
      end
      FILL: begin
        if (mem_ack) next_state = DONE;  // Wait states just hold here
      end
      WRITE: begin
        if (mem_ack) next_state = DONE;
      end
      DONE: begin
        next_state = IDLE;  // Master may hold cyc, IDLE samples again
      end
      default: begin
        next_state = CLEAR;
      end
    endcase
  end

  assign mem_bus = (next_state == FILL) || (next_state == WRITE);

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state     <= CLEAR;
      start_q   <= 1'b1;  // Sweep starts in the first cycle after reset
      ack_q     <= 1'b0;
      mem_cyc_q <= 1'b0;
      mem_stb_q <= 1'b0;
      mem_we_q  <= 1'b0;
    end else begin
      state     <= next_state;
      start_q   <= 1'b0;
      ack_q     <= (next_state == DONE);
      mem_cyc_q <= mem_bus;                 // Up from the cycle after LOOKUP
      mem_stb_q <= mem_bus;                 // Classic bus, no idle strobe gaps
      mem_we_q  <= (next_state == WRITE);
    end
  end

  assign clear_start = start_q;
  assign clearing    = (state == CLEAR) && !clear_done;  // Exactly 2048 sweep cycles

  assign cpu_ack = ack_q;
  assign mem_cyc = mem_cyc_q;
  assign mem_stb = mem_stb_q;
  assign mem_we  = mem_we_q;

  // Stores take the line on the memory ack edge
  assign tag_we   = ((state == FILL) || (state == WRITE)) && mem_ack;
  assign data_we  = tag_we;
  assign fill_sel = (state == FILL);  // Memory word is the fill source

  // Ack only answers a live request
  a_ack_with_req: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(cpu_ack) |-> cpu_req) else $error("cpu_ack without cyc and stb");

  // Memory strobe never outside a memory cycle
  a_stb_in_cyc: assert property (@(posedge clk) disable iff (!reset_n)
    mem_stb |-> mem_cyc) else $error("mem_stb without mem_cyc");

endmodule

// File: clear_counter.sv
`timescale 1ns/1ps

// Walks every line index once after reset
module clear_counter (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              clear_start,  // One-cycle start pulse
  output cache_pkg::index_t clear_index,
  output logic              clear_done
);

  import cache_pkg::*;

  index_t count;    // Index being cleared this cycle
  logic   running;  // Sweep in progress after the start cycle
  logic   active;   // Index is written this cycle

  assign active = (clear_start || running) && !clear_done;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      count      <= '0;
      running    <= 1'b0;
      clear_done <= 1'b0;
    end else if (active) begin
      if (count == index_t'(NUM_LINES - 1)) begin  // Last line written
        running    <= 1'b0;
        clear_done <= 1'b1;
      end else begin
        count   <= count + 1'b1;
        running <= 1'b1;
      end
    end
  end

  assign clear_index = count;

  // Done is sticky until the next reset
  a_done_sticky: assert property (@(posedge clk) disable iff (!reset_n)
    clear_done |=> clear_done) else $error("clear_done dropped before reset");

endmodule

// File: data_store.sv
`timescale 1ns/1ps

// Word array from two byte-wide SRAMs
module data_store (
  input  logic              clk,
  input  cache_pkg::index_t index,
  input  logic              data_we,   // Write the selected word
  input  logic              fill_sel,  // 1 = memory word, 0 = CPU word
  input  cache_pkg::word_t  cpu_word,
  input  cache_pkg::word_t  mem_word,
  output cache_pkg::word_t  rd_word
);

  import cache_pkg::*;

  word_t wr_word;  // Write source after the fill mux
  byte_t rd_hi;    // High byte chip output
  byte_t rd_lo;    // Low byte chip output
  logic  wr_n;     // Shared write strobe for both chips

  // Miss fill takes the memory word, write-through takes the CPU word
  assign wr_word = fill_sel ? mem_word : cpu_word;
  assign wr_n    = !data_we;

  // Bits 15:8
  sram_2k8 data_hi_i (
    .clk     (clk),
    .address (index),
    .cs_n    (1'b0),
    .oe_n    (1'b0),
    .w_n     (wr_n),
    .d       (wr_word[15:8]),
    .d_out   (rd_hi)
  );

  // Bits 7:0
  sram_2k8 data_lo_i (
    .clk     (clk),
    .address (index),
    .cs_n    (1'b0),
    .oe_n    (1'b0),
    .w_n     (wr_n),
    .d       (wr_word[7:0]),
    .d_out   (rd_lo)
  );

  assign rd_word = {rd_hi, rd_lo};  // Reads zero while a write is in progress

endmodule

// File: tag_store.sv
`timescale 1ns/1ps

// Tag SRAM, one byte per index laid out as {valid, tag}
module tag_store (
  input  logic              clk,
  input  cache_pkg::index_t index,
  input  cache_pkg::tag_t   tag,
  input  logic              tag_we,    // Write valid entry for tag
  input  logic              clearing,  // Sweep writes invalid entries
  output logic              hit
);

  import cache_pkg::*;

  byte_t wr_entry;  // Entry written into the SRAM
  byte_t rd_entry;  // Entry read back for compare
  logic  wr_n;      // SRAM write strobe
  logic  rd_off_n;  // SRAM output enable

  // Invalid entry is all zero, valid bit in the top position
  assign wr_entry = clearing ? '0 : {1'b1, tag};

  assign wr_n     = !(tag_we || clearing);
  assign rd_off_n = clearing;  // Nothing to compare during the sweep

  sram_2k8 tag_ram_i (
    .clk     (clk),
    .address (index),
    .cs_n    (1'b0),       // Always selected
    .oe_n    (rd_off_n),
    .w_n     (wr_n),
    .d       (wr_entry),
    .d_out   (rd_entry)
  );

  // Hit when stored entry is valid and tags agree
  always_comb begin
    hit = 1'b0;
    if (rd_entry[7] && (rd_entry[6:0] == tag)) begin
      hit = 1'b1;
    end
  end

endmodule

// File: sram_2k8.sv
`timescale 1ns/1ps

// 2K x 8 static RAM with the chip-style control pins
// Write is taken on the clock edge so the array maps to block RAM
module sram_2k8 (
  input  logic              clk,
  input  cache_pkg::index_t address,
  input  logic              cs_n,     // Chip select, active low
  input  logic              oe_n,     // Output enable, active low
  input  logic              w_n,      // Write enable, active low
  input  cache_pkg::byte_t  d,
  output cache_pkg::byte_t  d_out
);

  import cache_pkg::*;

  byte_t mem [NUM_LINES];  // Contents undefined at power-up

  logic write_en;  // Selected and write strobe low
  logic read_en;   // Selected, output enabled, not writing

  assign write_en = !cs_n && !w_n;
  assign read_en  = !cs_n && !oe_n && w_n;

  always_ff @(posedge clk) begin
    if (write_en) begin
      mem[address] <= d;
    end
  end

  // Async read, output forced low when not driving
  assign d_out = read_en ? mem[address] : '0;

  // Write strobe only ever issued to a selected chip
  a_write_needs_cs: assert property (@(posedge clk) !w_n |-> !cs_n)
    else $error("sram_2k8 w_n low while deselected");

endmodule

// File: cache_pkg.sv
package cache_pkg;

  // Geometry fixed by the 2K x 8 SRAM parts
  localparam int INDEX_BITS = 11;               // One SRAM address per line
  localparam int TAG_BITS   = 7;                // Fits beside the valid bit in one byte
  localparam int NUM_LINES  = 2 ** INDEX_BITS;  // 2048 lines, one word each

  // CPU word address is tag over index
  typedef logic [TAG_BITS+INDEX_BITS-1:0] addr_t;  // 18 bit word address
  typedef logic [INDEX_BITS-1:0]          index_t; // Line index and SRAM address
  typedef logic [TAG_BITS-1:0]            tag_t;   // Upper address part
  typedef logic [15:0]                    word_t;  // CPU data word
  typedef logic [7:0]                     byte_t;  // One SRAM location

  // Controller states
  typedef enum logic [2:0] {
    CLEAR,   // Post-reset sweep of the tag store
    IDLE,    // Waiting for cyc and stb
    LOOKUP,  // Tag compare on the async SRAM read
    FILL,    // Read miss, memory read in flight
    WRITE,   // Write-through, memory write in flight
    DONE     // Ack to the CPU
  } ctrl_state_t;

endpackage
